// ==== verilog/avl_pkg.sv ====
package avl_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;  // Bit n selects byte n

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;  // All zero means read
  } mem_req_t;

  typedef struct packed {
    data_t rdata;
    logic  ready;
  } mem_rsp_t;

  typedef struct packed {
    addr_t address;
    strb_t byteenable;
    logic  read;
    logic  write;
    data_t writedata;
  } avl_cmd_t;

  typedef struct packed {
    data_t readdata;
    logic  waitrequest;
    logic  readdatavalid;
  } avl_rsp_t;

  typedef enum logic [1:0] {idle, load, store} bridge_state_t;
  typedef enum logic [1:0] {ram_idle, ram_wait, ram_reply} ram_state_t;
  typedef enum logic [1:0] {grant_none, grant_data, grant_fetch} grant_t;

  localparam int ram_words = 256;
  localparam int ram_index_bits = 8;  // Word index is address[9:2]
  localparam int wait_cycles = 2;
  localparam int wait_bits = $clog2(wait_cycles + 1);

  typedef logic [wait_bits-1:0] wait_cnt_t;

endpackage

// ==== verilog/avl_arbiter.sv ====
module avl_arbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  avl_pkg::fetch_req_t  fetch_req,
  output avl_pkg::mem_rsp_t    fetch_rsp,
  input  avl_pkg::mem_req_t    data_req,
  output avl_pkg::mem_rsp_t    data_rsp,
  output avl_pkg::mem_req_t    bus_req,
  input  avl_pkg::mem_rsp_t    bus_rsp
);

  avl_pkg::grant_t   owner;
  avl_pkg::grant_t   grant;
  avl_pkg::mem_req_t fetch_wide;

  // Fetch never writes, so the strobe stays zero
  always_comb begin
    fetch_wide.valid = fetch_req.valid;
    fetch_wide.addr = fetch_req.addr;
    fetch_wide.wdata = '0;
    fetch_wide.wstrb = '0;
  end

  always_comb begin
    grant = owner;
    if (owner == avl_pkg::grant_none) begin
      if (data_req.valid) begin
        grant = avl_pkg::grant_data;  // Data port has priority
      end else if (fetch_req.valid) begin
        grant = avl_pkg::grant_fetch;
      end
    end
  end

  always_comb begin
    case (grant)
      avl_pkg::grant_data: begin
        bus_req = data_req;
      end
      avl_pkg::grant_fetch: begin
        bus_req = fetch_wide;
      end
      default: begin
        bus_req = '0;
      end
    endcase
  end

  always_comb begin
    data_rsp.ready = bus_rsp.ready && (owner == avl_pkg::grant_data);
    data_rsp.rdata = (owner == avl_pkg::grant_data) ? bus_rsp.rdata : '0;
    fetch_rsp.ready = bus_rsp.ready && (owner == avl_pkg::grant_fetch);
    fetch_rsp.rdata = (owner == avl_pkg::grant_fetch) ? bus_rsp.rdata : '0;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      owner <= avl_pkg::grant_none;
    end else if (bus_rsp.ready) begin
      owner <= avl_pkg::grant_none;  // Release on completion
    end else begin
      owner <= grant;
    end
  end

  // Ready only reaches a port that is still requesting
  assert property (@(posedge clk) disable iff (!rst)
    data_rsp.ready |-> data_req.valid);
  assert property (@(posedge clk) disable iff (!rst)
    fetch_rsp.ready |-> fetch_req.valid);

endmodule

// ==== verilog/avl.sv ====
module avl (
  input  logic               clk,
  input  logic               rst,
  input  avl_pkg::mem_req_t  bus_req,
  output avl_pkg::mem_rsp_t  bus_rsp,
  output avl_pkg::avl_cmd_t  avl_cmd,
  input  avl_pkg::avl_rsp_t  avl_rsp
);

  avl_pkg::bridge_state_t state;
  avl_pkg::bridge_state_t state_next;
  avl_pkg::avl_cmd_t      cmd_new;
  avl_pkg::avl_cmd_t      cmd_reg;

  // Command built straight from the request
  always_comb begin
    cmd_new.address = bus_req.addr;
    cmd_new.byteenable = bus_req.wstrb;
    cmd_new.writedata = bus_req.wdata;
    cmd_new.read = bus_req.valid & ~(|bus_req.wstrb);
    cmd_new.write = bus_req.valid & (|bus_req.wstrb);
  end

  // Held copy drives the bus once a transfer is under way
  assign avl_cmd = (state == avl_pkg::idle) ? cmd_new : cmd_reg;

  always_comb begin
    state_next = state;
    bus_rsp.rdata = '0;
    bus_rsp.ready = 1'b0;
    case (state)
      avl_pkg::idle: begin
        if (cmd_new.read) begin
          state_next = avl_pkg::load;
        end else if (cmd_new.write) begin
          state_next = avl_pkg::store;
        end
      end
      avl_pkg::load: begin
        if (!avl_rsp.waitrequest && avl_rsp.readdatavalid) begin
          state_next = avl_pkg::idle;
          bus_rsp.rdata = avl_rsp.readdata;
          bus_rsp.ready = 1'b1;
        end
      end
      avl_pkg::store: begin
        if (!avl_rsp.waitrequest) begin  // Write accepted
          state_next = avl_pkg::idle;
          bus_rsp.ready = 1'b1;
        end
      end
      default: begin
        state_next = avl_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= avl_pkg::idle;
      cmd_reg.read <= 1'b0;
      cmd_reg.write <= 1'b0;
    end else begin
      state <= state_next;
      cmd_reg <= avl_cmd;
    end
  end

  // A stalled command stays on the bus until accepted
  assert property (@(posedge clk) disable iff (!rst)
    (avl_cmd.read || avl_cmd.write) && avl_rsp.waitrequest |=> $stable(avl_cmd));

endmodule

// ==== verilog/avl_ram.sv ====
module avl_ram (
  input  logic               clk,
  input  logic               rst,
  input  avl_pkg::avl_cmd_t  avl_cmd,
  output avl_pkg::avl_rsp_t  avl_rsp
);

  avl_pkg::ram_state_t             state;
  avl_pkg::ram_state_t             state_next;
  avl_pkg::wait_cnt_t              wait_cnt;
  logic [avl_pkg::ram_index_bits-1:0] index;
  logic                            cmd_valid;
  logic                            accept;
  avl_pkg::data_t                  readdata;
  avl_pkg::data_t                  mem [avl_pkg::ram_words];

  assign index = avl_cmd.address[avl_pkg::ram_index_bits+1:2];  // Wraps at 1 KiB
  assign cmd_valid = avl_cmd.read | avl_cmd.write;
  assign accept = (state == avl_pkg::ram_wait) && (wait_cnt == '0) && cmd_valid;

  always_comb begin
    state_next = state;
    case (state)
      avl_pkg::ram_idle: begin
        if (cmd_valid) begin
          state_next = avl_pkg::ram_wait;
        end
      end
      avl_pkg::ram_wait: begin
        if (!cmd_valid) begin
          state_next = avl_pkg::ram_idle;  // Master dropped the command
        end else if (wait_cnt == '0) begin
          state_next = avl_cmd.read ? avl_pkg::ram_reply : avl_pkg::ram_idle;
        end
      end
      default: begin
        state_next = avl_pkg::ram_idle;  // Reply lasts one cycle
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= avl_pkg::ram_idle;
      wait_cnt <= '0;
    end else begin
      state <= state_next;
      if (state == avl_pkg::ram_idle) begin
        wait_cnt <= avl_pkg::wait_cnt_t'(avl_pkg::wait_cycles - 1);  // Idle cycle counts
      end else if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      if (avl_cmd.write) begin
        for (int i = 0; i < $bits(avl_pkg::strb_t); i++) begin
          if (avl_cmd.byteenable[i]) begin
            mem[index][8*i +: 8] <= avl_cmd.writedata[8*i +: 8];
          end
        end
      end else begin
        readdata <= mem[index];
      end
    end
  end

  always_comb begin
    avl_rsp.readdata = readdata;
    avl_rsp.readdatavalid = (state == avl_pkg::ram_reply);
    avl_rsp.waitrequest = cmd_valid &&
      ((state == avl_pkg::ram_idle) || ((state == avl_pkg::ram_wait) && (wait_cnt != '0)));
  end

  // Read data only follows a read accepted on the previous edge
  assert property (@(posedge clk) disable iff (!rst)
    avl_rsp.readdatavalid |-> $past(avl_cmd.read && !avl_rsp.waitrequest));

endmodule

// ==== verilog/avl_subsys.sv ====
module avl_subsys (
  input  logic                 clk,
  input  logic                 rst,
  input  avl_pkg::fetch_req_t  fetch_req,
  output avl_pkg::mem_rsp_t    fetch_rsp,
  input  avl_pkg::mem_req_t    data_req,
  output avl_pkg::mem_rsp_t    data_rsp
);

  avl_pkg::mem_req_t bus_req;
  avl_pkg::mem_rsp_t bus_rsp;
  avl_pkg::avl_cmd_t avl_cmd;
  avl_pkg::avl_rsp_t avl_rsp;

  avl_arbiter u_arbiter (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .data_req  (data_req),
    .data_rsp  (data_rsp),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp)
  );

  avl u_avl (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .avl_cmd (avl_cmd),
    .avl_rsp (avl_rsp)
  );

  avl_ram u_ram (
    .clk     (clk),
    .rst     (rst),
    .avl_cmd (avl_cmd),
    .avl_rsp (avl_rsp)
  );

endmodule

// ==== bench/avl_tasks.svh ====
function automatic int ref_index(input avl_pkg::addr_t addr);
  return (addr / 4) % avl_pkg::ram_words;  // Word address wraps at 1 KiB
endfunction

function automatic avl_pkg::data_t merge_bytes(input avl_pkg::data_t old_word,
                                               input avl_pkg::data_t new_word,
                                               input avl_pkg::strb_t strb);
  avl_pkg::data_t word;
  word = old_word;
  for (int i = 0; i < 4; i++) begin
    if (strb[i]) begin
      word[8*i +: 8] = new_word[8*i +: 8];
    end
  end
  return word;
endfunction

task automatic ref_write(input avl_pkg::addr_t addr, input avl_pkg::data_t data,
                         input avl_pkg::strb_t strb);
  ref_mem[ref_index(addr)] = merge_bytes(ref_mem[ref_index(addr)], data, strb);
  ref_valid[ref_index(addr)] = 1'b1;
endtask

task automatic abort_run(input string line);
  $display("%s", line);
  $display("Simulation failed");
  $fatal(1);
endtask

task automatic check_value(input string test, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (actual !== expected) begin
    abort_run($sformatf("ERROR: %s expected 0x%08h actual 0x%08h", test, expected, actual));
  end
endtask

// Holds valid until ready, counting cycles from the first valid cycle
task automatic data_access(input avl_pkg::addr_t addr, input avl_pkg::data_t wdata,
                           input avl_pkg::strb_t strb, output avl_pkg::data_t rdata,
                           output int cycles);
  @(posedge clk);
  #drive_delay;
  data_req.valid = 1'b1;
  data_req.addr = addr;
  data_req.wdata = wdata;
  data_req.wstrb = strb;
  cycles = 0;
  @(negedge clk);
  while (data_rsp.ready !== 1'b1) begin
    cycles++;
    if (cycles > ready_limit) begin
      abort_run("Timeout: data port gave no ready within 20 cycles");
    end else begin
      @(negedge clk);
    end
  end
  rdata = data_rsp.rdata;
  @(posedge clk);
  #drive_delay;
  data_req.valid = 1'b0;
endtask

task automatic fetch_access(input avl_pkg::addr_t addr, output avl_pkg::data_t rdata,
                            output int cycles);
  @(posedge clk);
  #drive_delay;
  fetch_req.valid = 1'b1;
  fetch_req.addr = addr;
  cycles = 0;
  @(negedge clk);
  while (fetch_rsp.ready !== 1'b1) begin
    cycles++;
    if (cycles > ready_limit) begin
      abort_run("Timeout: fetch port gave no ready within 20 cycles");
    end else begin
      @(negedge clk);
    end
  end
  rdata = fetch_rsp.rdata;
  @(posedge clk);
  #drive_delay;
  fetch_req.valid = 1'b0;
endtask

task automatic write_word(input string test, input avl_pkg::addr_t addr,
                          input avl_pkg::data_t data, input avl_pkg::strb_t strb);
  avl_pkg::data_t rdata;
  int             cycles;
  data_access(addr, data, strb, rdata, cycles);
  check_value({test, " write latency"}, 2, cycles);
  ref_write(addr, data, strb);
endtask

task automatic read_word(input string test, input avl_pkg::addr_t addr);
  avl_pkg::data_t rdata;
  int             cycles;
  data_access(addr, '0, '0, rdata, cycles);
  check_value({test, " read latency"}, 3, cycles);
  check_value(test, ref_mem[ref_index(addr)], rdata);
endtask

task automatic fetch_word(input string test, input avl_pkg::addr_t addr);
  avl_pkg::data_t rdata;
  int             cycles;
  fetch_access(addr, rdata, cycles);
  check_value({test, " fetch latency"}, 3, cycles);
  check_value(test, ref_mem[ref_index(addr)], rdata);
endtask

task automatic reset_idle();
  rst = 1'b0;
  repeat (reset_cycles) begin
    @(negedge clk);
    check_value("reset_idle", 0, data_rsp.ready);
    check_value("reset_idle", 0, fetch_rsp.ready);
  end
  @(posedge clk);
  #drive_delay;
  rst = 1'b1;
  repeat (5) begin
    @(negedge clk);
    check_value("reset_idle", 0, data_rsp.ready);
    check_value("reset_idle", 0, fetch_rsp.ready);
  end
endtask

task automatic data_write_read();
  avl_pkg::addr_t addrs [4] = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0010, 32'h0000_03fc};
  avl_pkg::data_t words [4] = '{32'h1357_9bdf, 32'hdead_beef, 32'h0123_4567, 32'ha5a5_5a5a};
  for (int i = 0; i < 4; i++) begin
    write_word("data_write_read", addrs[i], words[i], 4'hf);
  end
  for (int i = 0; i < 4; i++) begin
    read_word("data_write_read", addrs[i]);
  end
endtask

task automatic byte_strobe();
  write_word("byte_strobe", 32'h0000_0040, 32'h1122_3344, 4'hf);
  write_word("byte_strobe", 32'h0000_0040, 32'haabb_ccdd, 4'b0010);
  read_word("byte_strobe", 32'h0000_0040);
  write_word("byte_strobe", 32'h0000_0040, 32'h5566_7788, 4'b1100);  // Upper half word
  read_word("byte_strobe", 32'h0000_0040);
  write_word("byte_strobe", 32'h0000_0040, 32'h99aa_bbcc, 4'b0001);
  read_word("byte_strobe", 32'h0000_0040);
endtask

task automatic fetch_read();
  fetch_word("fetch_read", 32'h0000_0000);
  fetch_word("fetch_read", 32'h0000_0010);
  fetch_word("fetch_read", 32'h0000_0410);  // Aliases 0x010
  fetch_word("fetch_read", 32'h0000_07fc);  // Aliases 0x3fc
endtask

task automatic contention();
  avl_pkg::data_t data_rdata;
  avl_pkg::data_t fetch_rdata;
  int             data_cycles;
  int             fetch_cycles;
  fork
    data_access(32'h0000_0080, 32'hcafe_f00d, 4'hf, data_rdata, data_cycles);
    fetch_access(32'h0000_0004, fetch_rdata, fetch_cycles);
  join
  check_value("contention data latency", 2, data_cycles);
  check_value("contention fetch latency", 2 + 1 + 3, fetch_cycles);  // Waits for the write
  check_value("contention", ref_mem[ref_index(32'h0000_0004)], fetch_rdata);
  ref_write(32'h0000_0080, 32'hcafe_f00d, 4'hf);
  fork
    data_access(32'h0000_0080, '0, '0, data_rdata, data_cycles);
    fetch_access(32'h0000_0410, fetch_rdata, fetch_cycles);
  join
  check_value("contention data latency", 3, data_cycles);
  check_value("contention fetch latency", 3 + 1 + 3, fetch_cycles);
  check_value("contention", ref_mem[ref_index(32'h0000_0080)], data_rdata);
  check_value("contention", ref_mem[ref_index(32'h0000_0410)], fetch_rdata);
endtask

task automatic random_mix();
  avl_pkg::addr_t addr;
  avl_pkg::data_t wdata;
  avl_pkg::strb_t strb;
  logic [31:0]    r;
  for (int i = 0; i < random_count; i++) begin
    addr = $random(seed) & 32'h0000_0c7c;  // 32 words plus aliases above 1 KiB
    wdata = $random(seed);
    r = $random(seed);
    strb = r[3:0];
    if (!ref_valid[ref_index(addr)]) begin
      strb = 4'hf;  // First touch writes a whole word
    end else if (r[4]) begin
      strb = '0;
    end else if (strb == '0) begin
      strb = 4'hf;
    end
    if (strb == '0) begin
      read_word("random_mix", addr);
    end else begin
      write_word("random_mix", addr, wdata, strb);
    end
    if (i % 4 == 3) begin
      addr = $random(seed) & 32'h0000_0c7c;
      if (!ref_valid[ref_index(addr)]) begin
        addr = 32'h0000_0010;
      end
      fetch_word("random_mix", addr);
    end
  end
endtask

// ==== bench/avl_subsys_tb.sv ====
module avl_subsys_tb;

  localparam int period = 100;
  localparam int drive_delay = 10;
  localparam int reset_cycles = 10;
  localparam int ready_limit = 20;
  localparam int random_count = 40;
  localparam int request_count = 73;  // All port requests over all tests

  logic                clk;
  logic                rst;
  avl_pkg::fetch_req_t fetch_req;
  avl_pkg::mem_rsp_t   fetch_rsp;
  avl_pkg::mem_req_t   data_req;
  avl_pkg::mem_rsp_t   data_rsp;

  avl_pkg::data_t ref_mem [avl_pkg::ram_words];  // Expected RAM contents
  logic           ref_valid [avl_pkg::ram_words];
  integer         seed = 59;

  avl_subsys u_dut (
    .clk       (clk),
    .rst       (rst),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .data_req  (data_req),
    .data_rsp  (data_rsp)
  );

  `include "avl_tasks.svh"

  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

  initial begin
    #((request_count * 10 + reset_cycles) * period);
    abort_run("Watchdog expired before all tests finished");
  end

  // Only one port may complete in a cycle
  always @(negedge clk) begin
    if (data_rsp.ready === 1'b1 && fetch_rsp.ready === 1'b1) begin
      abort_run("Data and fetch ready were high in the same cycle");
    end
  end

  initial begin
    rst = 1'b0;
    fetch_req = '0;
    data_req = '0;
    for (int i = 0; i < avl_pkg::ram_words; i++) begin
      ref_valid[i] = 1'b0;
    end
    reset_idle();
    data_write_read();
    byte_strobe();
    fetch_read();
    contention();
    random_mix();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== avl_subsys.f ====
+incdir+bench
verilog/avl_pkg.sv
verilog/avl_arbiter.sv
verilog/avl.sv
verilog/avl_ram.sv
verilog/avl_subsys.sv
bench/avl_subsys_tb.sv
